// ==== src.f ====
logic/pcecd_pkg.sv
logic/pcecd_bus_if.sv
logic/cd_cpu_regs.sv
logic/cd_bus_sequencer.sv
logic/cd_cmd_decoder.sv
logic/pcecd_top.sv
sim/pcecd_chk.sv
sim/pcecd_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
SEED      ?= 2952
TOP       ?= pcecd_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS    := $(shell grep -v '^+' src.f)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f src.f

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/pcecd_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcecd_tb import pcecd_pkg::*; #(parameter int SEED = 32'hb88);

	typedef logic [7:0] byte_q_t [$];

	localparam int MAX_CYCLES = 20000;	// ~56 handshakes x ~4 steps x 32 clocks plus poll slack
	localparam int POLL_LIMIT = 50;	// Status reads before a wait gives up

	logic        CLOCK;
	logic        SCSI_RST;
	logic        CS_N;
	logic        WR_N;
	logic        RD_N;
	logic [20:0] ADDR;
	logic [7:0]  DIN;
	logic [7:0]  DOUT;
	logic        irq2;

	logic [7:0] int_mask_val;	// IRQ enables kept under the ACK bit
	logic [7:0] exp_q [$];	// Data-in scoreboard
	logic [7:0] got_q [$];
	int         seed;
	int         cycle_cnt = 0;

	pcecd_top dut0 (
		.CLOCK(CLOCK),
		.SCSI_RST(SCSI_RST),
		.CS_N(CS_N),
		.WR_N(WR_N),
		.RD_N(RD_N),
		.ADDR(ADDR),
		.DIN(DIN),
		.DOUT(DOUT),
		.irq2(irq2)
	);

	initial CLOCK = 1'b0;
	always #5 CLOCK = ~CLOCK;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s exp %02h got %02h", name, exp, got));
	endtask

	// Expected GET_DIR_INFO reply from the BCD TOC of the fixed disc
	function automatic byte_q_t expect_reply(input logic [7:0] sub, input logic [7:0] track);
		byte_q_t     r;
		logic [31:0] bytes;
		int          n;
		bytes = 32'h0;
		n = 0;
		case (sub)
			8'h00: begin
				bytes = 32'h01220000;	// First and last track
				n = 2;
			end
			8'h01: begin
				bytes = 32'h49091200;	// Disc length MSF
				n = 3;
			end
			8'h02: begin
				n = 4;
				case (track)
					8'h01:   bytes = 32'h00020000;
					8'h02:   bytes = 32'h00536504;
					8'hAA:   bytes = 32'h00000004;	// Lead-out
					default: n = 0;
				endcase
			end
			default: n = 0;
		endcase
		for (int i = 0; i < n; i++)
			r.push_back(bytes[31-8*i -: 8]);
		return r;
	endfunction

	function automatic logic [20:0] reg_addr(input logic [7:0] off);
		return {13'h0018, off};	// $18xx window
	endfunction

	task automatic cpu_write(input logic [20:0] addr, input logic [7:0] data);
		@(posedge CLOCK);
		ADDR <= addr;
		DIN  <= data;
		CS_N <= 1'b0;
		WR_N <= 1'b0;
		repeat (5) @(posedge CLOCK);	// Strobe lands on the 4th edge
		CS_N <= 1'b1;
		WR_N <= 1'b1;
		repeat (3) @(posedge CLOCK);	// Sync chain sees WR_N high again
	endtask

	task automatic cpu_read(input logic [20:0] addr, output logic [7:0] data);
		@(posedge CLOCK);
		ADDR <= addr;
		CS_N <= 1'b0;
		RD_N <= 1'b0;
		@(negedge CLOCK);
		data = DOUT;	// Before the RD_N strobe can touch BRAM_LOCK
		repeat (5) @(posedge CLOCK);
		CS_N <= 1'b1;
		RD_N <= 1'b1;
		repeat (3) @(posedge CLOCK);
	endtask

	task automatic poll_status(input logic [7:0] mask, input logic [7:0] want, input string what);
		logic [7:0] stat;
		int         polls;
		polls = 0;
		cpu_read(reg_addr(ADDR_STATUS), stat);
		while ((stat & mask) != want) begin
			polls++;
			if (polls > POLL_LIMIT)
				abort_run({what, " never showed up in the status register"});
			cpu_read(reg_addr(ADDR_STATUS), stat);
		end
	endtask

	task automatic wait_req(input logic level);
		poll_status(8'h40, level ? 8'h40 : 8'h00, level ? "REQ high" : "REQ low");
	endtask

	// CPU half of REQ/ACK with ACK in INT_MASK bit 7
	task automatic ack_byte();
		cpu_write(reg_addr(ADDR_INT_MASK), int_mask_val | 8'h80);
		wait_req(1'b0);
		cpu_write(reg_addr(ADDR_INT_MASK), int_mask_val);
	endtask

	task automatic send_byte(input logic [7:0] b);
		wait_req(1'b1);
		cpu_write(reg_addr(ADDR_DATABUS), b);
		ack_byte();
	endtask

	task automatic recv_byte(input logic [7:0] exp_stat, output logic [7:0] b);
		logic [7:0] stat;
		wait_req(1'b1);
		cpu_read(reg_addr(ADDR_STATUS), stat);
		check_val("status", stat, exp_stat);
		cpu_read(reg_addr(ADDR_DATABUS), b);
		ack_byte();
	endtask

	// Select, packet out, replies in, status, message, bus free
	task automatic run_command(input byte_q_t pkt, input byte_q_t reply);
		logic [7:0] got;
		cpu_write(reg_addr(ADDR_STATUS), SEL_CODE);
		wait_req(1'b1);
		cpu_read(reg_addr(ADDR_STATUS), got);
		check_val("status", got, 8'hD1);	// BSY REQ CD with ID 0
		foreach (pkt[i])
			send_byte(pkt[i]);
		foreach (reply[i]) begin
			exp_q.push_back(reply[i]);
			recv_byte(8'hC9, got);	// DATA_IN
			got_q.push_back(got);
		end
		recv_byte(8'hD9, got);
		check_val("status_byte", got, 8'h00);
		recv_byte(8'hF9, got);
		check_val("message_byte", got, 8'h00);
		poll_status(8'h80, 8'h00, "Bus free");
		cpu_read(reg_addr(ADDR_STATUS), got);
		check_val("status", got, 8'h00);
		if (exp_q.size() != 0 || got_q.size() != 0)
			abort_run("Data-in scoreboard still holds bytes at bus free");
	endtask

	task automatic dir_info(input logic [7:0] sub, input logic [7:0] track);
		byte_q_t pkt;
		pkt.push_back(GET_DIR_INFO);
		pkt.push_back(sub);
		pkt.push_back(track);
		while (pkt.size() < 10)
			pkt.push_back(8'h00);	// NEC packets are 10 bytes
		run_command(pkt, expect_reply(sub, track));
	endtask

	// Compare data-in bytes against the reference
	always @(posedge CLOCK) begin
		if (exp_q.size() != 0 && got_q.size() != 0)
			check_val("databus", got_q.pop_front(), exp_q.pop_front());
	end

	always @(posedge CLOCK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			abort_run("Timeout, the test sequence did not finish in time");
		else if (dut0.u_seq.chk0.fail_cnt != 0)
			abort_run("A sequencer assertion failed");
	end

	initial begin
		logic [7:0] got;
		logic [7:0] saved [16];
		int         rnd;
		byte_q_t    pkt;
		byte_q_t    none;
		seed = SEED;
		int_mask_val = 8'h00;
		SCSI_RST <= 1'b1;
		CS_N     <= 1'b1;
		WR_N     <= 1'b1;
		RD_N     <= 1'b1;
		ADDR     <= 21'h0;
		DIN      <= 8'h00;
		repeat (5) @(posedge CLOCK);
		SCSI_RST <= 1'b0;
		@(posedge CLOCK);

		// Reset values and signature bytes
		cpu_read(reg_addr(ADDR_STATUS), got);
		check_val("status", got, 8'h00);
		cpu_read(reg_addr(8'hC1), got);
		check_val("sig_18c1", got, 8'hAA);
		cpu_read(reg_addr(8'hC7), got);
		check_val("sig_18c7", got, 8'h03);
		cpu_read(reg_addr(8'h10), got);
		check_val("unmapped", got, 8'hFF);
		check_val("irq2", {7'd0, irq2}, 8'h00);

		// Plain storage at $1805..$180F
		for (int off = 5; off < 16; off++) begin
			rnd = $random(seed);
			saved[off] = rnd[7:0];
			cpu_write(reg_addr(8'(off)), saved[off]);
		end
		for (int off = 5; off < 16; off++) begin
			cpu_read(reg_addr(8'(off)), got);
			check_val($sformatf("reg_%02h", off), got, saved[off]);
		end

		pkt.push_back(TEST_UNIT_READY);
		repeat (5) pkt.push_back(8'h00);
		run_command(pkt, none);

		dir_info(8'h00, 8'h01);
		dir_info(8'h01, 8'h02);
		dir_info(8'h02, 8'hAA);

		// IRQ2 then a bus reset in the middle of a packet
		cpu_write(reg_addr(ADDR_BRAM_LOCK), 8'h7C);
		int_mask_val = 8'h04;
		cpu_write(reg_addr(ADDR_INT_MASK), int_mask_val);
		@(negedge CLOCK);
		check_val("irq2", {7'd0, irq2}, 8'h01);
		cpu_write(reg_addr(ADDR_STATUS), SEL_CODE);
		send_byte(TEST_UNIT_READY);
		send_byte(8'h00);
		cpu_write(reg_addr(ADDR_CD_RESET), 8'h02);
		cpu_read(reg_addr(ADDR_STATUS), got);
		check_val("status", got, 8'h00);
		cpu_read(reg_addr(ADDR_BRAM_LOCK), got);
		check_val("bram_lock", got, 8'h0C);

		repeat (4) @(posedge CLOCK);
		if (dut0.u_seq.chk0.fail_cnt == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else
			abort_run("Sequencer assertions failed during the run");
	end

endmodule

`default_nettype wire

// ==== sim/pcecd_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcecd_chk import pcecd_pkg::*; (
	input logic      CLOCK,
	input logic      SCSI_RST,
	input cd_phase_e phase,
	input logic      req,
	input logic      drive_load
);

	localparam int BUSY_LIMIT = 128 << STEP_DIV_W;	// 128 handshake steps

	int unsigned busy_cycles;	// Clocks since last BUS_FREE
	int unsigned fail_cnt = 0;

	always_ff @(posedge CLOCK) begin
		if (SCSI_RST || phase == BUS_FREE)
			busy_cycles <= 0;
		else
			busy_cycles <= busy_cycles + 1;
	end

	req_idle: assert property (@(posedge CLOCK) disable iff (SCSI_RST)
		phase == BUS_FREE |-> !req)
		else begin
			$error("REQ high during BUS_FREE");
			fail_cnt++;
		end

	load_phase: assert property (@(posedge CLOCK) disable iff (SCSI_RST)
		drive_load |-> phase inside {DATA_IN, STATUS, MESSAGE_IN})
		else begin
			$error("drive_load outside a drive-to-host phase");
			fail_cnt++;
		end

	back_to_free: assert property (@(posedge CLOCK) disable iff (SCSI_RST)
		busy_cycles < BUSY_LIMIT)
		else begin
			$error("Bus did not return to BUS_FREE in time");
			fail_cnt++;
		end

endmodule

bind cd_bus_sequencer pcecd_chk chk0 (
	.CLOCK(CLOCK),
	.SCSI_RST(SCSI_RST),
	.phase(phase),
	.req(bus.req),
	.drive_load(bus.drive_load)
);

`default_nettype wire

// ==== logic/pcecd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcecd_top import pcecd_pkg::*; (
	input  logic        CLOCK,
	input  logic        SCSI_RST,
	input  logic        CS_N,
	input  logic        WR_N,
	input  logic        RD_N,
	input  logic [20:0] ADDR,
	input  logic [7:0]  DIN,
	output logic [7:0]  DOUT,
	output logic        irq2
);

	logic [7:0] cmd_bytes [CMD_BUF_DEPTH];	// Command packet, sequencer to decoder
	logic       cmd_start;
	logic       cmd_done;
	logic [3:0] packet_len;
	cd_phase_e  next_phase;
	logic [3:0] reply_len;
	logic [1:0] reply_index;
	logic [7:0] reply_byte;

	pcecd_bus_if bus ();

	cd_cpu_regs u_regs (
		.CLOCK(CLOCK),
		.SCSI_RST(SCSI_RST),
		.CS_N(CS_N),
		.WR_N(WR_N),
		.RD_N(RD_N),
		.ADDR(ADDR),
		.DIN(DIN),
		.DOUT(DOUT),
		.irq2(irq2),
		.bus(bus.regs)
	);

	cd_bus_sequencer u_seq (
		.CLOCK(CLOCK),
		.SCSI_RST(SCSI_RST),
		.bus(bus.seq),
		.cmd_bytes(cmd_bytes),
		.cmd_start(cmd_start),
		.reply_index(reply_index),
		.packet_len(packet_len),
		.cmd_done(cmd_done),
		.next_phase(next_phase),
		.reply_len(reply_len),
		.reply_byte(reply_byte)
	);

	cd_cmd_decoder u_dec (
		.CLOCK(CLOCK),
		.SCSI_RST(SCSI_RST),
		.cmd_bytes(cmd_bytes),
		.cmd_start(cmd_start),
		.reply_index(reply_index),
		.packet_len(packet_len),
		.cmd_done(cmd_done),
		.next_phase(next_phase),
		.reply_len(reply_len),
		.reply_byte(reply_byte)
	);

endmodule

`default_nettype wire

// ==== logic/cd_cmd_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module cd_cmd_decoder import pcecd_pkg::*; (
	input  logic       CLOCK,
	input  logic       SCSI_RST,
	input  logic [7:0] cmd_bytes [CMD_BUF_DEPTH],
	input  logic       cmd_start,
	input  logic [1:0] reply_index,
	output logic [3:0] packet_len,
	output logic       cmd_done,
	output cd_phase_e  next_phase,
	output logic [3:0] reply_len,
	output logic [7:0] reply_byte
);

	cd_opcode_e opcode;
	logic [7:0] dir_bytes [4];
	logic [3:0] dir_len;	// Zero when there is no data-in reply
	logic [7:0] reply_buf [4];

	assign opcode = cd_opcode_e'(cmd_bytes[0]);
	assign reply_byte = reply_buf[reply_index];

	always_comb begin
		case (opcode)
			TEST_UNIT_READY, READ6: packet_len = 4'd6;
			SET_AUDIO_START, SET_AUDIO_STOP, PAUSE,
			GET_SUBQ, GET_DIR_INFO: packet_len = 4'd10;	// NEC vendor group
			default: packet_len = 4'd1;
		endcase
	end

	// GET_DIR_INFO table pick by sub-code in byte 1 and BCD track in byte 2
	always_comb begin
		dir_len = 4'd0;
		dir_bytes = '{default: 8'h00};
		if (opcode == GET_DIR_INFO) begin
			case (cmd_bytes[1])
				8'h00: begin
					dir_bytes[0] = DIR_FIRST_LAST[0];
					dir_bytes[1] = DIR_FIRST_LAST[1];
					dir_len = 4'd2;
				end
				8'h01: begin	// Disc length in MSF
					dir_bytes[0] = DIR_DISC_SIZE[0];
					dir_bytes[1] = DIR_DISC_SIZE[1];
					dir_bytes[2] = DIR_DISC_SIZE[2];
					dir_len = 4'd3;
				end
				8'h02: begin
					dir_len = 4'd4;
					case (cmd_bytes[2])
						8'h01:   dir_bytes = DIR_TRACK1;
						8'h02:   dir_bytes = DIR_TRACK2;
						8'hAA:   dir_bytes = DIR_LEAD_OUT;
						default: dir_len = 4'd0;	// No such track so status only
					endcase
				end
				default: ;
			endcase
		end
	end

	// TEST_UNIT_READY and everything else go straight to STATUS
	always_ff @(posedge CLOCK) begin
		if (SCSI_RST) begin
			cmd_done   <= 1'b0;
			next_phase <= BUS_FREE;
			reply_len  <= 4'd0;
		end else begin
			cmd_done <= cmd_start;	// One clock to execute
			if (cmd_start) begin
				reply_len  <= dir_len;
				next_phase <= (dir_len != 4'd0) ? DATA_IN : STATUS;
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		if (cmd_start)
			reply_buf <= dir_bytes;
	end

endmodule

`default_nettype wire

// ==== logic/cd_bus_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cd_bus_sequencer import pcecd_pkg::*; (
	input  logic       CLOCK,
	input  logic       SCSI_RST,
	pcecd_bus_if.seq   bus,
	output logic [7:0] cmd_bytes [CMD_BUF_DEPTH],
	output logic       cmd_start,
	output logic [1:0] reply_index,
	input  logic [3:0] packet_len,
	input  logic       cmd_done,
	input  cd_phase_e  next_phase,
	input  logic [3:0] reply_len,
	input  logic [7:0] reply_byte
);

	// Steps of one byte transfer, shared by all phases
	typedef enum logic [2:0] {
		ST_WAIT_ACK,	// REQ up, wait for CPU ACK
		ST_WAIT_NACK,
		ST_TAKE,	// Byte done, act on it
		ST_PRESENT,	// Next byte or next phase
		ST_EXEC	// Decoder busy
	} step_e;

	cd_phase_e             phase;
	step_e                 step;
	logic [STEP_DIV_W-1:0] step_div;
	logic [3:0]            byte_cnt;	// Command bytes in, or reply bytes out
	logic                  tick;
	logic                  cmd_take;

	assign tick = &step_div;
	assign reply_index = byte_cnt[1:0];	// Replies are at most 4 bytes
	assign cmd_take = tick && phase == COMMAND && step == ST_TAKE;

	// Phase bits of the status byte
	always_comb begin
		bus.bsy = (phase != BUS_FREE);
		bus.msg = (phase == MESSAGE_IN);
		bus.cd = (phase == COMMAND) || (phase == STATUS) || (phase == MESSAGE_IN);
		bus.io = (phase == DATA_IN) || (phase == STATUS) || (phase == MESSAGE_IN);
		bus.scsi_id = (phase != BUS_FREE) ? 3'b001 : 3'b000;	// Drive is ID 0
	end

	always_ff @(posedge CLOCK) begin
		if (SCSI_RST)
			step_div <= '0;
		else
			step_div <= step_div + 1'b1;
	end

	always_ff @(posedge CLOCK) begin
		if (cmd_take)
			cmd_bytes[byte_cnt] <= bus.host_byte;	// Grab the packet byte
	end

	always_ff @(posedge CLOCK) begin
		if (SCSI_RST) begin
			phase               <= BUS_FREE;
			step                <= ST_WAIT_ACK;
			byte_cnt            <= 4'd0;
			bus.req             <= 1'b0;
			bus.drive_byte      <= 8'h00;
			bus.drive_load      <= 1'b0;
			bus.xfer_done_pulse <= 1'b0;
			cmd_start           <= 1'b0;
		end else begin
			bus.drive_load      <= 1'b0;
			bus.xfer_done_pulse <= 1'b0;
			cmd_start           <= 1'b0;

			if (bus.bus_reset || bus.deselect_pulse) begin
				bus.xfer_done_pulse <= (phase != BUS_FREE);
				phase   <= BUS_FREE;
				bus.req <= 1'b0;
				step    <= ST_WAIT_ACK;
			end else if (bus.select_pulse) begin
				phase    <= COMMAND;
				bus.req  <= 1'b1;	// Ask for first command byte
				step     <= ST_WAIT_ACK;
				byte_cnt <= 4'd0;
			end else if (phase == COMMAND && step == ST_EXEC) begin
				if (cmd_done) begin	// Not tied to the step tick
					phase    <= next_phase;
					step     <= ST_PRESENT;
					byte_cnt <= 4'd0;
				end
			end else if (phase != BUS_FREE && tick) begin
				case (step)
					ST_WAIT_ACK: if (bus.ack) begin
						bus.req <= 1'b0;
						step <= ST_WAIT_NACK;
					end
					ST_WAIT_NACK: if (!bus.ack) step <= ST_TAKE;
					ST_TAKE: begin
						step <= ST_PRESENT;
						case (phase)
							COMMAND, DATA_IN: byte_cnt <= byte_cnt + 4'd1;
							STATUS: phase <= MESSAGE_IN;
							default: begin	// Message taken, release the bus
								phase <= BUS_FREE;
								bus.xfer_done_pulse <= 1'b1;
							end
						endcase
					end
					ST_PRESENT: begin
						case (phase)
							COMMAND: if (byte_cnt < packet_len) begin
								bus.req <= 1'b1;
								step <= ST_WAIT_ACK;
							end else begin
								cmd_start <= 1'b1;	// Packet complete
								step <= ST_EXEC;
							end
							DATA_IN: if (byte_cnt < reply_len) begin
								bus.drive_byte <= reply_byte;
								bus.drive_load <= 1'b1;
								bus.req <= 1'b1;
								step <= ST_WAIT_ACK;
							end else
								phase <= STATUS;	// Status presented next tick
							default: begin	// STATUS and MESSAGE_IN both send 0x00
								bus.drive_byte <= 8'h00;
								bus.drive_load <= 1'b1;
								bus.req <= 1'b1;
								step <= ST_WAIT_ACK;
							end
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/cd_cpu_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module cd_cpu_regs import pcecd_pkg::*; (
	input  logic        CLOCK,
	input  logic        SCSI_RST,
	input  logic        CS_N,
	input  logic        WR_N,
	input  logic        RD_N,
	input  logic [20:0] ADDR,
	input  logic [7:0]  DIN,
	output logic [7:0]  DOUT,
	output logic        irq2,
	pcecd_bus_if.regs   bus
);

	logic [3:0] rd_sh;	// Two sync stages, two for the edge
	logic [3:0] wr_sh;
	logic       rd_stb;
	logic       wr_stb;
	logic       aux_hit;
	logic [7:0] cdc_cmd;
	logic [7:0] int_mask;
	logic [7:0] bram_lock;
	logic [7:0] cd_reset;
	logic [7:0] status_byte;
	logic [7:0] aux_regs [5:15];	// $1805..$180F, ADPCM side, plain storage here

	assign rd_stb = rd_sh[3] & ~rd_sh[2] & ~CS_N;	// Falling RD_N
	assign wr_stb = wr_sh[3] & ~wr_sh[2] & ~CS_N;
	assign aux_hit = (ADDR[7:4] == 4'h0) && (ADDR[3:0] > 4'h4);

	assign bus.host_byte = cdc_cmd;
	assign bus.ack = int_mask[7];	// ACK lives in INT_MASK

	always_ff @(posedge CLOCK) begin
		if (SCSI_RST) begin
			rd_sh <= 4'hF;	// Idle high
			wr_sh <= 4'hF;
		end else begin
			rd_sh <= {rd_sh[2:0], RD_N};
			wr_sh <= {wr_sh[2:0], WR_N};
		end
	end

	always_ff @(posedge CLOCK) begin
		if (SCSI_RST) begin
			cdc_cmd            <= 8'h00;
			int_mask           <= 8'h00;
			bram_lock          <= 8'h00;
			cd_reset           <= 8'h00;
			irq2               <= 1'b0;
			bus.select_pulse   <= 1'b0;
			bus.deselect_pulse <= 1'b0;
			bus.bus_reset      <= 1'b0;
		end else begin
			bus.select_pulse   <= 1'b0;
			bus.deselect_pulse <= 1'b0;
			bus.bus_reset      <= 1'b0;
			irq2 <= |(int_mask & bram_lock & IRQ_MASK_BITS);	// IRQ2 refresh

			if (bus.drive_load)
				cdc_cmd <= bus.drive_byte;	// Drive puts data/status/message here
			if (bus.xfer_done_pulse)
				bram_lock <= bram_lock & ~XFER_DONE_BIT;
			if (rd_stb && ADDR[7:0] == ADDR_BRAM_LOCK)
				bram_lock <= bram_lock ^ 8'h02;	// Reading BRAM_LOCK flips bit 1

			if (wr_stb) begin
				case (ADDR[7:0])
					ADDR_STATUS: bus.select_pulse <= (DIN == SEL_CODE);	// Selection
					ADDR_DATABUS: begin
						cdc_cmd <= DIN;
						bus.deselect_pulse <= (DIN == SEL_CODE);
					end
					ADDR_INT_MASK:  int_mask  <= DIN;
					ADDR_BRAM_LOCK: bram_lock <= DIN;
					ADDR_CD_RESET: begin
						cd_reset <= DIN;
						if (DIN[1]) begin	// Bit 1 resets the CD bus
							bus.bus_reset <= 1'b1;
							bram_lock <= bram_lock & LOCK_KEEP_ON_RESET;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		if (wr_stb && aux_hit)
			aux_regs[ADDR[3:0]] <= DIN;
	end

	always_comb begin
		status_byte = {5'b00000, bus.scsi_id};
		status_byte[STAT_BSY] = bus.bsy;
		status_byte[STAT_REQ] = bus.req;
		status_byte[STAT_MSG] = bus.msg;
		status_byte[STAT_CD]  = bus.cd;
		status_byte[STAT_IO]  = bus.io;
	end

	// Read mux, straight off ADDR
	always_comb begin
		DOUT = 8'hFF;	// Unmapped
		case (ADDR[7:0])
			8'hC1, 8'hC5:   DOUT = 8'hAA;	// Super System Card signature
			8'hC2, 8'hC6:   DOUT = 8'h55;
			8'hC3:          DOUT = 8'h00;
			8'hC7:          DOUT = 8'h03;
			ADDR_STATUS:    DOUT = status_byte;
			ADDR_DATABUS:   DOUT = cdc_cmd;
			ADDR_INT_MASK:  DOUT = int_mask;
			ADDR_BRAM_LOCK: DOUT = bram_lock;
			ADDR_CD_RESET:  DOUT = cd_reset;
			default: if (aux_hit) DOUT = aux_regs[ADDR[3:0]];
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/pcecd_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Register file <-> bus sequencer
interface pcecd_bus_if;
	logic [7:0] host_byte;	// CDC_CMD as written by the CPU
	logic       select_pulse;
	logic       deselect_pulse;
	logic       ack;	// INT_MASK bit 7
	logic       bus_reset;
	logic       bsy;
	logic       req;
	logic       msg;
	logic       cd;
	logic       io;
	logic [2:0] scsi_id;
	logic [7:0] drive_byte;	// Byte from drive, overwrites CDC_CMD
	logic       drive_load;
	logic       xfer_done_pulse;

	modport regs (output host_byte, select_pulse, deselect_pulse, ack, bus_reset,
		input bsy, req, msg, cd, io, scsi_id, drive_byte, drive_load, xfer_done_pulse);
	modport seq (input host_byte, select_pulse, deselect_pulse, ack, bus_reset,
		output bsy, req, msg, cd, io, scsi_id, drive_byte, drive_load, xfer_done_pulse);
endinterface

`default_nettype wire

// ==== logic/pcecd_pkg.sv ====
`default_nettype none

package pcecd_pkg;

	// CPU register offsets in the $1800 window
	localparam logic [7:0] ADDR_STATUS    = 8'h00;	// CDC_STAT
	localparam logic [7:0] ADDR_DATABUS   = 8'h01;	// CDC_CMD
	localparam logic [7:0] ADDR_INT_MASK  = 8'h02;	// INT_MASK, bit 7 is ACK
	localparam logic [7:0] ADDR_BRAM_LOCK = 8'h03;
	localparam logic [7:0] ADDR_CD_RESET  = 8'h04;

	// Host ID 7 ORed with drive ID 0
	localparam logic [7:0] SEL_CODE = 8'h81;

	localparam logic [7:0] IRQ_MASK_BITS      = 8'h7C;	// IRQ sources shared by mask and lock
	localparam logic [7:0] LOCK_KEEP_ON_RESET = 8'h8F;
	localparam logic [7:0] XFER_DONE_BIT      = 8'h20;

	// Status byte layout, ID in bits 2..0
	localparam int STAT_BSY = 7;
	localparam int STAT_REQ = 6;
	localparam int STAT_MSG = 5;
	localparam int STAT_CD  = 4;
	localparam int STAT_IO  = 3;

	localparam int STEP_DIV_W    = 5;	// One handshake step per 32 clocks
	localparam int CMD_BUF_DEPTH = 16;

	typedef enum logic [2:0] {
		BUS_FREE,
		COMMAND,
		DATA_IN,
		STATUS,
		MESSAGE_IN
	} cd_phase_e;

	typedef enum logic [7:0] {
		TEST_UNIT_READY = 8'h00,
		READ6           = 8'h08,
		SEL_RESET       = 8'h81,
		SET_AUDIO_START = 8'hD8,
		SET_AUDIO_STOP  = 8'hD9,
		PAUSE           = 8'hDA,
		GET_SUBQ        = 8'hDD,
		GET_DIR_INFO    = 8'hDE,
		END_OF_LIST     = 8'hFF
	} cd_opcode_e;

	// Fixed disc TOC, BCD
	localparam logic [7:0] DIR_FIRST_LAST [2] = '{8'h01, 8'h22};	// First, last track
	localparam logic [7:0] DIR_DISC_SIZE  [3] = '{8'h49, 8'h09, 8'h12};	// M, S, F
	localparam logic [7:0] DIR_TRACK1     [4] = '{8'h00, 8'h02, 8'h00, 8'h00};	// Audio
	localparam logic [7:0] DIR_TRACK2     [4] = '{8'h00, 8'h53, 8'h65, 8'h04};	// Data
	localparam logic [7:0] DIR_LEAD_OUT   [4] = '{8'h00, 8'h00, 8'h00, 8'h04};

endpackage

`default_nettype wire
